// File: flist.f
+incdir+logic
logic/id_types_pkg.sv
logic/rv_isa_pkg.sv
logic/id_pipe_latch.sv
logic/id_decoder.sv
logic/id_gpr_file.sv
logic/id_operand_bypass.sv
logic/id_branch_unit.sv
logic/id_stage.sv
verification/id_stage_sva.sv
verification/id_stage_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the decode stage testbench with verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module id_stage_tb -f flist.f -o id_stage_sim \
  > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/id_stage_sim > sim.log 2>&1
cat sim.log
! grep -q "STATUS: FAIL" sim.log && grep -q "STATUS: PASS" sim.log || exit 1

// File: verification/id_stage_tb.sv
// decode stage testbench with clock, reset, random stimulus, reference model and checks
`timescale 1ns/1ps
`include "id_settings.svh"

module id_stage_tb import id_types_pkg::*, rv_isa_pkg::*; ();

  localparam int N_TRANSFERS    = 2000;
  localparam int TIMEOUT_CYCLES = N_TRANSFERS * 4;  // about twice the expected run

  logic      i_clk;
  logic      i_rst_n;
  logic      i_fs_valid;
  inst_t     i_fs_inst;
  pc_t       i_fs_pc;
  logic      i_es_allowin;
  logic      i_wb_wen;
  gpr_addr_t i_wb_waddr;
  xlen_t     i_wb_wdata;
  gpr_addr_t i_es_rd;
  xlen_t     i_es_result;
  logic      i_es_is_load;
  gpr_addr_t i_ms_rd;
  xlen_t     i_ms_result;
  gpr_addr_t i_ws_rd;
  xlen_t     i_ws_result;
  logic      o_ds_allowin;
  logic      o_es_valid;
  pc_t       o_es_pc;
  xlen_t     o_es_rs1_data;
  xlen_t     o_es_rs2_data;
  xlen_t     o_es_imm;
  alu_op_e   o_es_alu_op;
  logic      o_es_src1_pc;
  logic      o_es_src2_imm;
  gpr_addr_t o_es_rd;
  logic      o_es_gpr_wen;
  logic      o_es_mem_ren;
  logic      o_es_mem_wen;
  logic      o_es_invalid;
  logic      o_br_taken;
  pc_t       o_br_target;

  integer    seed;
  int        cycles;
  int        n_transfers;
  int        n_stalls;
  int        n_taken;
  int        wr_idx;

  // reference state
  xlen_t     shadow [0:31];
  logic      model_valid;
  inst_t     model_inst;
  pc_t       model_pc;
  logic      exp_allowin;

  // expected decode of model_inst
  gpr_addr_t exp_rd;
  xlen_t     exp_imm;
  alu_op_e   exp_alu;
  logic      exp_src1_pc, exp_src2_imm, exp_wen, exp_ren, exp_mwen, exp_inv;
  logic      exp_is_br, exp_is_jal, exp_is_jalr;

  // expected outputs of the previous cycle under back-pressure
  logic      hold_prev;
  pc_t       held_pc;
  xlen_t     held_imm;
  alu_op_e   held_alu;
  gpr_addr_t held_rd;

  id_stage uut (.*);

  always #2 i_clk = ~i_clk;  // 4 ns period

  task automatic abort_run();
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(input string name, input xlen_t exp, input xlen_t act);
    if (act !== exp) begin
      $display("ERROR %s expected 0x%h got 0x%h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_addr(input string name, input gpr_addr_t exp, input gpr_addr_t act);
    if (act !== exp) begin
      $display("ERROR %s expected 0x%h got 0x%h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_alu(input string name, input alu_op_e exp, input alu_op_e act);
    if (act !== exp) begin
      $display("ERROR %s expected 0x%h got 0x%h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERROR %s expected 0x%h got 0x%h", name, exp, act);
      abort_run();
    end
  endtask

  // one random instruction, mostly from the supported subset
  task automatic make_inst(output inst_t inst);
    logic [31:0] r;
    logic [31:0] f;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [4:0]  rd, rs1, rs2;
    logic        legal;
    int          kind;
    r     = $random(seed);
    f     = $random(seed);
    kind  = $unsigned($random(seed)) % 17;
    legal = (f[1:0] != 2'b00);
    rd    = {2'b00, r[2:0]};  // x0..x7 so producers and consumers collide
    rs1   = {2'b00, r[5:3]};
    rs2   = {2'b00, r[8:6]};
    f3    = r[11:9];
    f7    = legal ? {1'b0, f[2], 5'b00000} : r[31:25];
    case (kind / 2)
      0: inst = {r[31:12], rd, OPC_LUI};
      1: inst = {r[31:12], rd, OPC_JAL};
      2: inst = {r[31:20], rs1, legal ? 3'b000 : f3, rd, OPC_JALR};
      3: inst = {r[31:25], rs2, rs1, f3, r[16:12], OPC_BRANCH};
      4: inst = {r[31:20], rs1, legal ? 3'b010 : f3, rd, OPC_LOAD};
      5: inst = {r[31:25], rs2, rs1, legal ? 3'b010 : f3, r[16:12], OPC_STORE};
      6: inst = {(f3 == 3'b001 || f3 == 3'b101) ? f7 : r[31:25], rs2, rs1, f3, rd, OPC_OP_IMM};
      7: inst = {f7, rs2, rs1, f3, rd, OPC_OP};
      default: inst = {r[31:7], f[4] ? 7'b0001111 : 7'b1110011};  // fence or system
    endcase
  endtask

  task automatic drive_inputs();
    logic [31:0] r;
    logic [31:0] p;
    inst_t       inst;
    r = $random(seed);
    p = $random(seed);
    make_inst(inst);
    i_fs_inst    <= inst;
    i_fs_pc      <= {p[31:2], 2'b00};
    i_fs_valid   <= (r[1:0] != 2'b00) && (wr_idx >= 32);
    i_es_allowin <= (r[3:2] != 2'b00);  // ready about 3 of 4 cycles
    i_es_is_load <= (r[5:4] == 2'b00);
    i_es_rd      <= {2'b00, r[8:6]};
    i_ms_rd      <= {2'b00, r[11:9]};
    i_ws_rd      <= {2'b00, r[14:12]};
    i_es_result  <= $random(seed);
    i_ms_result  <= $random(seed);
    i_ws_result  <= $random(seed);
    i_wb_wdata   <= $random(seed);
    if (wr_idx < 32) begin
      // every register written once before any real traffic
      i_wb_wen   <= 1'b1;
      i_wb_waddr <= wr_idx[4:0];
      wr_idx     = wr_idx + 1;
    end else begin
      i_wb_wen   <= r[15];
      i_wb_waddr <= r[19] ? r[20:16] : {2'b00, r[18:16]};
    end
  endtask

  // reference decode from the rv32i encodings
  task automatic ref_decode(input inst_t inst);
    logic [2:0] f3;
    logic [6:0] f7;
    alu_op_e    fn_alu;
    f3           = inst[14:12];
    f7           = inst[31:25];
    exp_imm      = '0;
    exp_alu      = ALU_ADD;
    exp_src1_pc  = 1'b0;
    exp_src2_imm = 1'b0;
    exp_wen      = 1'b0;
    exp_ren      = 1'b0;
    exp_mwen     = 1'b0;
    exp_is_br    = 1'b0;
    exp_is_jal   = 1'b0;
    exp_is_jalr  = 1'b0;
    exp_inv      = 1'b0;
    case (f3)
      3'b000:  fn_alu = (inst[6:0] == OPC_OP && f7[5]) ? ALU_SUB : ALU_ADD;
      3'b001:  fn_alu = ALU_SLL;
      3'b010:  fn_alu = ALU_SLT;
      3'b011:  fn_alu = ALU_SLTU;
      3'b100:  fn_alu = ALU_XOR;
      3'b101:  fn_alu = f7[5] ? ALU_SRA : ALU_SRL;
      3'b110:  fn_alu = ALU_OR;
      default: fn_alu = ALU_AND;
    endcase
    case (inst[6:0])
      OPC_LUI: begin
        exp_imm      = {inst[31:12], 12'h000};
        exp_alu      = ALU_PASS_B;
        exp_src2_imm = 1'b1;
        exp_wen      = 1'b1;
      end
      OPC_JAL: begin
        exp_imm     = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        exp_src1_pc = 1'b1;
        exp_wen     = 1'b1;
        exp_is_jal  = 1'b1;
      end
      OPC_JALR: begin
        exp_imm     = {{20{inst[31]}}, inst[31:20]};
        exp_src1_pc = 1'b1;
        exp_wen     = 1'b1;
        exp_is_jalr = 1'b1;
        exp_inv     = (f3 != 3'b000);
      end
      OPC_BRANCH: begin
        exp_imm   = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        exp_is_br = 1'b1;
        exp_inv   = (f3 == 3'b010 || f3 == 3'b011);
      end
      OPC_LOAD: begin
        exp_imm      = {{20{inst[31]}}, inst[31:20]};
        exp_src2_imm = 1'b1;
        exp_wen      = 1'b1;
        exp_ren      = 1'b1;
        exp_inv      = (f3 != 3'b010);
      end
      OPC_STORE: begin
        exp_imm      = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        exp_src2_imm = 1'b1;
        exp_mwen     = 1'b1;
        exp_inv      = (f3 != 3'b010);
      end
      OPC_OP_IMM: begin
        exp_imm      = {{20{inst[31]}}, inst[31:20]};
        exp_alu      = fn_alu;
        exp_src2_imm = 1'b1;
        exp_wen      = 1'b1;
        exp_inv      = (f3 == 3'b001 && f7 != 7'h00) ||
                       (f3 == 3'b101 && f7 != 7'h00 && f7 != 7'h20);
      end
      OPC_OP: begin
        exp_alu = fn_alu;
        exp_wen = 1'b1;
        exp_inv = (f7 != 7'h00) && !(f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
      end
      default: exp_inv = 1'b1;
    endcase
    if (exp_inv) begin
      exp_wen     = 1'b0;
      exp_ren     = 1'b0;
      exp_mwen    = 1'b0;
      exp_is_br   = 1'b0;
      exp_is_jal  = 1'b0;
      exp_is_jalr = 1'b0;
    end
    exp_rd = exp_wen ? inst[11:7] : 5'd0;
  endtask

  // newest producer first, then the shadow registers
  function automatic xlen_t fwd(input gpr_addr_t rs);
    xlen_t v;
    if (rs == 5'd0) begin
      v = '0;
    end else if (rs == i_es_rd) begin
      v = i_es_result;
    end else if (rs == i_ms_rd) begin
      v = i_ms_result;
    end else if (rs == i_ws_rd) begin
      v = i_ws_result;
    end else begin
      v = shadow[rs];
    end
    return v;
  endfunction

  task automatic check_cycle();
    gpr_addr_t rs1, rs2;
    xlen_t     rs1_v, rs2_v;
    pc_t       target;
    logic      stall, exp_valid, fire, cond, taken;
    rs1   = model_inst[19:15];
    rs2   = model_inst[24:20];
    ref_decode(model_inst);
    rs1_v = fwd(rs1);
    rs2_v = fwd(rs2);
    stall = i_es_is_load && i_es_rd != 5'd0 && (i_es_rd == rs1 || i_es_rd == rs2);
    exp_valid   = model_valid && !stall;
    exp_allowin = !model_valid || (!stall && i_es_allowin);
    fire        = exp_valid && i_es_allowin;
    case (model_inst[14:12])
      BR_BEQ:  cond = (rs1_v == rs2_v);
      BR_BNE:  cond = (rs1_v != rs2_v);
      BR_BLT:  cond = ($signed(rs1_v) < $signed(rs2_v));
      BR_BGE:  cond = !($signed(rs1_v) < $signed(rs2_v));
      BR_BLTU: cond = (rs1_v < rs2_v);
      BR_BGEU: cond = !(rs1_v < rs2_v);
      default: cond = 1'b0;
    endcase
    taken  = fire && ((exp_is_br && cond) || exp_is_jal || exp_is_jalr);
    target = exp_is_jalr ? ((rs1_v + exp_imm) & ~32'h1) : (model_pc + exp_imm);

    check_bit("o_es_valid", exp_valid, o_es_valid);
    check_bit("o_ds_allowin", exp_allowin, o_ds_allowin);
    check_word("o_es_pc", model_pc, o_es_pc);
    check_addr("o_es_rd", exp_rd, o_es_rd);
    check_bit("o_es_invalid", exp_inv, o_es_invalid);
    check_bit("o_es_gpr_wen", exp_wen, o_es_gpr_wen);
    check_bit("o_es_mem_ren", exp_ren, o_es_mem_ren);
    check_bit("o_es_mem_wen", exp_mwen, o_es_mem_wen);
    if (!exp_inv) begin
      check_word("o_es_imm", exp_imm, o_es_imm);
      check_alu("o_es_alu_op", exp_alu, o_es_alu_op);
      check_bit("o_es_src1_pc", exp_src1_pc, o_es_src1_pc);
      check_bit("o_es_src2_imm", exp_src2_imm, o_es_src2_imm);
    end
    check_word("o_es_rs1_data", rs1_v, o_es_rs1_data);
    check_word("o_es_rs2_data", rs2_v, o_es_rs2_data);
    check_bit("o_br_taken", taken, o_br_taken);
    if (fire && (exp_is_br || exp_is_jal || exp_is_jalr)) begin
      check_word("o_br_target", target, o_br_target);
    end
    if (hold_prev) begin
      check_word("o_es_pc held", held_pc, o_es_pc);
      check_addr("o_es_rd held", held_rd, o_es_rd);
      if (!exp_inv) begin
        check_word("o_es_imm held", held_imm, o_es_imm);
        check_alu("o_es_alu_op held", held_alu, o_es_alu_op);
      end
    end
    hold_prev = model_valid && !i_es_allowin;
    held_pc   = model_pc;
    held_imm  = exp_imm;
    held_alu  = exp_alu;
    held_rd   = exp_rd;
    if (model_valid && stall) begin
      n_stalls = n_stalls + 1;
    end
    if (taken) begin
      n_taken = n_taken + 1;
    end
  endtask

  // state the coming edge will load
  task automatic update_model();
    if (i_wb_wen && i_wb_waddr != 5'd0) begin
      shadow[i_wb_waddr] = i_wb_wdata;
    end
    if (exp_allowin) begin
      model_valid = i_fs_valid;
      if (i_fs_valid) begin
        model_inst  = i_fs_inst;
        model_pc    = i_fs_pc;
        n_transfers = n_transfers + 1;
      end
    end
  endtask

  initial begin
    seed         = 32'hdcda_e4fc;
    i_clk        = 1'b0;
    i_rst_n      <= 1'b0;
    i_fs_valid   <= 1'b0;
    i_fs_inst    <= '0;
    i_fs_pc      <= '0;
    i_es_allowin <= 1'b0;
    i_wb_wen     <= 1'b0;
    i_wb_waddr   <= '0;
    i_wb_wdata   <= '0;
    i_es_rd      <= '0;
    i_es_result  <= '0;
    i_es_is_load <= 1'b0;
    i_ms_rd      <= '0;
    i_ms_result  <= '0;
    i_ws_rd      <= '0;
    i_ws_result  <= '0;
    model_valid  = 1'b0;
    model_inst   = '0;
    model_pc     = `RESET_PC;
    hold_prev    = 1'b0;
    n_transfers  = 0;
    n_stalls     = 0;
    n_taken      = 0;
    wr_idx       = 1;
    repeat (5) @(posedge i_clk);
    i_rst_n <= 1'b1;
    while (n_transfers < N_TRANSFERS) begin
      drive_inputs();
      @(negedge i_clk);  // outputs settled
      check_cycle();
      update_model();
      @(posedge i_clk);
    end
    if (n_stalls == 0 || n_taken == 0) begin
      $display("stimulus never produced a load-use stall or a taken redirect");
      abort_run();
    end else begin
      $display("STATUS: PASS");
      $finish;
    end
  end

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge i_clk);
      cycles = cycles + 1;
    end
    $display("timeout after %0d cycles with only %0d transfers done", cycles, n_transfers);
    abort_run();
  end

endmodule

// File: verification/id_stage_sva.sv
// concurrent assertions on the decode handshake, redirect and load-use stall
`timescale 1ns/1ps

module id_stage_sva import id_types_pkg::*; (
  input logic      i_clk,
  input logic      i_rst_n,
  input logic      i_es_allowin,
  input logic      i_es_is_load,
  input gpr_addr_t i_es_rd,
  input inst_t     i_inst,      // latched instruction
  input logic      i_es_valid,  // o_es_valid of the stage
  input logic      i_br_taken,
  input pc_t       i_es_pc
);

  // load in execute feeding rs1 or rs2 of the held instruction
  a_valid_no_stall : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_es_valid |-> !(i_es_is_load && (i_es_rd != '0) &&
                     ((i_es_rd == i_inst[19:15]) || (i_es_rd == i_inst[24:20]))))
    else $error("o_es_valid high while a load-use stall is pending");

  // redirect only on a fire
  a_taken_on_fire : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_br_taken |-> (i_es_valid && i_es_allowin))
    else $error("o_br_taken high outside a fire cycle");

  a_pc_held : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_es_valid && !i_es_allowin) |=> $stable(i_es_pc))
    else $error("o_es_pc changed under execute back-pressure");

endmodule

bind id_stage id_stage_sva u_sva (
  .i_clk        (i_clk),
  .i_rst_n      (i_rst_n),
  .i_es_allowin (i_es_allowin),
  .i_es_is_load (i_es_is_load),
  .i_es_rd      (i_es_rd),
  .i_inst       (ds_inst),
  .i_es_valid   (o_es_valid),
  .i_br_taken   (o_br_taken),
  .i_es_pc      (o_es_pc)
);

// File: logic/id_stage.sv
// decode stage top with latch, decoder, register file, bypass and branch unit
`timescale 1ns/1ps

module id_stage import id_types_pkg::*, rv_isa_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst_n,
  input  logic      i_fs_valid,
  input  inst_t     i_fs_inst,
  input  pc_t       i_fs_pc,
  input  logic      i_es_allowin,
  input  logic      i_wb_wen,
  input  gpr_addr_t i_wb_waddr,
  input  xlen_t     i_wb_wdata,
  input  gpr_addr_t i_es_rd,
  input  xlen_t     i_es_result,
  input  logic      i_es_is_load,
  input  gpr_addr_t i_ms_rd,
  input  xlen_t     i_ms_result,
  input  gpr_addr_t i_ws_rd,
  input  xlen_t     i_ws_result,
  output logic      o_ds_allowin,
  output logic      o_es_valid,
  output pc_t       o_es_pc,
  output xlen_t     o_es_rs1_data,
  output xlen_t     o_es_rs2_data,
  output xlen_t     o_es_imm,
  output alu_op_e   o_es_alu_op,
  output logic      o_es_src1_pc,
  output logic      o_es_src2_imm,
  output gpr_addr_t o_es_rd,
  output logic      o_es_gpr_wen,
  output logic      o_es_mem_ren,
  output logic      o_es_mem_wen,
  output logic      o_es_invalid,
  output logic      o_br_taken,
  output pc_t       o_br_target
);

  inst_t     ds_inst;
  logic      ds_fire;
  logic      load_stall;
  gpr_addr_t rs1, rs2;
  xlen_t     rf_rdata1, rf_rdata2;
  logic      is_branch, is_jal, is_jalr;
  br_func_e  br_func;

  id_pipe_latch u_latch (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_fs_valid   (i_fs_valid),
    .i_fs_inst    (i_fs_inst),
    .i_fs_pc      (i_fs_pc),
    .i_es_allowin (i_es_allowin),
    .i_load_stall (load_stall),
    .o_ds_allowin (o_ds_allowin),
    .o_es_valid   (o_es_valid),
    .o_fire       (ds_fire),
    .o_inst       (ds_inst),
    .o_pc         (o_es_pc)
  );

  id_decoder u_decoder (
    .i_inst      (ds_inst),
    .o_rs1       (rs1),
    .o_rs2       (rs2),
    .o_rd        (o_es_rd),
    .o_imm       (o_es_imm),
    .o_alu_op    (o_es_alu_op),
    .o_src1_pc   (o_es_src1_pc),
    .o_src2_imm  (o_es_src2_imm),
    .o_gpr_wen   (o_es_gpr_wen),
    .o_mem_ren   (o_es_mem_ren),
    .o_mem_wen   (o_es_mem_wen),
    .o_is_branch (is_branch),
    .o_is_jal    (is_jal),
    .o_is_jalr   (is_jalr),
    .o_br_func   (br_func),
    .o_invalid   (o_es_invalid)
  );

  id_gpr_file u_gprs (
    .i_clk    (i_clk),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .i_waddr  (i_wb_waddr),
    .i_wen    (i_wb_wen),
    .i_wdata  (i_wb_wdata),
    .o_rdata1 (rf_rdata1),
    .o_rdata2 (rf_rdata2)
  );

  id_operand_bypass u_bypass (
    .i_rs1        (rs1),
    .i_rs2        (rs2),
    .i_es_rd      (i_es_rd),
    .i_ms_rd      (i_ms_rd),
    .i_ws_rd      (i_ws_rd),
    .i_rf_rdata1  (rf_rdata1),
    .i_rf_rdata2  (rf_rdata2),
    .i_es_result  (i_es_result),
    .i_ms_result  (i_ms_result),
    .i_ws_result  (i_ws_result),
    .i_es_is_load (i_es_is_load),
    .o_rs1_data   (o_es_rs1_data),
    .o_rs2_data   (o_es_rs2_data),
    .o_load_stall (load_stall)
  );

  id_branch_unit u_bru (
    .i_fire      (ds_fire),
    .i_is_branch (is_branch),
    .i_is_jal    (is_jal),
    .i_is_jalr   (is_jalr),
    .i_br_func   (br_func),
    .i_rs1_data  (o_es_rs1_data),  // forwarded operands
    .i_rs2_data  (o_es_rs2_data),
    .i_imm       (o_es_imm),
    .i_pc        (o_es_pc),
    .o_br_taken  (o_br_taken),
    .o_br_target (o_br_target)
  );

endmodule

// File: logic/id_branch_unit.sv
// branch compare, jump target and redirect to fetch
`timescale 1ns/1ps

module id_branch_unit import id_types_pkg::*, rv_isa_pkg::*; (
  input  logic     i_fire,
  input  logic     i_is_branch,
  input  logic     i_is_jal,
  input  logic     i_is_jalr,
  input  br_func_e i_br_func,
  input  xlen_t    i_rs1_data,
  input  xlen_t    i_rs2_data,
  input  xlen_t    i_imm,
  input  pc_t      i_pc,
  output logic     o_br_taken,
  output pc_t      o_br_target
);

  logic cond;
  pc_t  pc_rel_target;
  pc_t  jalr_target;

  always_comb begin
    case (i_br_func)
      BR_BEQ:  cond = (i_rs1_data == i_rs2_data);
      BR_BNE:  cond = (i_rs1_data != i_rs2_data);
      BR_BLT:  cond = ($signed(i_rs1_data) < $signed(i_rs2_data));
      BR_BGE:  cond = ($signed(i_rs1_data) >= $signed(i_rs2_data));
      BR_BLTU: cond = (i_rs1_data < i_rs2_data);
      BR_BGEU: cond = (i_rs1_data >= i_rs2_data);
      default: cond = 1'b0;
    endcase
  end

  assign pc_rel_target = i_pc + i_imm;
  assign jalr_target   = (i_rs1_data + i_imm) & ~32'h1;  // lsb cleared per spec

  // redirect only once the instruction leaves decode
  assign o_br_taken  = i_fire & ((i_is_branch & cond) | i_is_jal | i_is_jalr);
  assign o_br_target = i_is_jalr ? jalr_target : pc_rel_target;

endmodule

// File: logic/id_operand_bypass.sv
// rs1/rs2 forwarding from execute, memory and write-back, load-use stall
`timescale 1ns/1ps

module id_operand_bypass import id_types_pkg::*; (
  input  gpr_addr_t i_rs1,
  input  gpr_addr_t i_rs2,
  input  gpr_addr_t i_es_rd,
  input  gpr_addr_t i_ms_rd,
  input  gpr_addr_t i_ws_rd,
  input  xlen_t     i_rf_rdata1,
  input  xlen_t     i_rf_rdata2,
  input  xlen_t     i_es_result,
  input  xlen_t     i_ms_result,
  input  xlen_t     i_ws_result,
  input  logic      i_es_is_load,
  output xlen_t     o_rs1_data,
  output xlen_t     o_rs2_data,
  output logic      o_load_stall
);

  // youngest producer wins, rd of 0 carries nothing
  function automatic xlen_t pick(input gpr_addr_t rs, input xlen_t rf_data);
    xlen_t data;
    if (i_es_rd != '0 && rs == i_es_rd) begin
      data = i_es_result;
    end else if (i_ms_rd != '0 && rs == i_ms_rd) begin
      data = i_ms_result;
    end else if (i_ws_rd != '0 && rs == i_ws_rd) begin
      data = i_ws_result;
    end else begin
      data = rf_data;
    end
    return data;
  endfunction

  assign o_rs1_data = pick(i_rs1, i_rf_rdata1);
  assign o_rs2_data = pick(i_rs2, i_rf_rdata2);

  // load data only exists once it reaches mem stage
  assign o_load_stall = i_es_is_load && (i_es_rd != '0) &&
                        ((i_es_rd == i_rs1) || (i_es_rd == i_rs2));

endmodule

// File: logic/id_gpr_file.sv
// 32x32 general purpose register file, two read ports, one write port
`timescale 1ns/1ps
`include "id_settings.svh"

module id_gpr_file import id_types_pkg::*; (
  input  logic      i_clk,
  input  gpr_addr_t i_raddr1,
  input  gpr_addr_t i_raddr2,
  input  gpr_addr_t i_waddr,
  input  logic      i_wen,
  input  xlen_t     i_wdata,
  output xlen_t     o_rdata1,
  output xlen_t     o_rdata2
);

  // x0 has no storage
  xlen_t regs [1:`GPR_NUM-1];

  always_ff @(posedge i_clk) begin
    if (i_wen && (i_waddr != '0)) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // same-cycle write is covered by the wb bypass
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

// File: logic/id_decoder.sv
// instruction field extraction, immediate generation and control decode
`timescale 1ns/1ps

module id_decoder import id_types_pkg::*, rv_isa_pkg::*; (
  input  inst_t     i_inst,
  output gpr_addr_t o_rs1,
  output gpr_addr_t o_rs2,
  output gpr_addr_t o_rd,
  output xlen_t     o_imm,
  output alu_op_e   o_alu_op,
  output logic      o_src1_pc,
  output logic      o_src2_imm,
  output logic      o_gpr_wen,
  output logic      o_mem_ren,
  output logic      o_mem_wen,
  output logic      o_is_branch,
  output logic      o_is_jal,
  output logic      o_is_jalr,
  output br_func_e  o_br_func,
  output logic      o_invalid
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  xlen_t      imm_i, imm_s, imm_b, imm_u, imm_j;

  // funct3 to alu op, alt selects sub/sra
  function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  assign opcode = opcode_e'(i_inst[6:0]);
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  assign o_rs1     = i_inst[19:15];
  assign o_rs2     = i_inst[24:20];
  assign o_rd      = o_gpr_wen ? i_inst[11:7] : '0;  // no result without write
  assign o_br_func = br_func_e'(funct3);

  assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {i_inst[31:12], 12'b0};
  assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  always_comb begin
    o_imm       = '0;
    o_alu_op    = ALU_ADD;
    o_src1_pc   = 1'b0;
    o_src2_imm  = 1'b0;
    o_gpr_wen   = 1'b0;
    o_mem_ren   = 1'b0;
    o_mem_wen   = 1'b0;
    o_is_branch = 1'b0;
    o_is_jal    = 1'b0;
    o_is_jalr   = 1'b0;
    o_invalid   = 1'b0;
    case (opcode)
      OPC_LUI: begin
        o_imm      = imm_u;
        o_alu_op   = ALU_PASS_B;
        o_src2_imm = 1'b1;
        o_gpr_wen  = 1'b1;
      end
      OPC_JAL: begin
        o_imm     = imm_j;
        o_src1_pc = 1'b1;  // link value pc+4 built in execute
        o_gpr_wen = 1'b1;
        o_is_jal  = 1'b1;
      end
      OPC_JALR: begin
        o_imm     = imm_i;
        o_src1_pc = 1'b1;
        o_gpr_wen = 1'b1;
        o_is_jalr = 1'b1;
        o_invalid = (funct3 != 3'b000);
      end
      OPC_BRANCH: begin
        o_imm       = imm_b;
        o_is_branch = 1'b1;
        o_invalid   = (funct3 == 3'b010) || (funct3 == 3'b011);
      end
      OPC_LOAD: begin
        o_imm      = imm_i;
        o_src2_imm = 1'b1;
        o_gpr_wen  = 1'b1;
        o_mem_ren  = 1'b1;
        o_invalid  = (funct3 != 3'b010);  // lw only
      end
      OPC_STORE: begin
        o_imm      = imm_s;
        o_src2_imm = 1'b1;
        o_mem_wen  = 1'b1;
        o_invalid  = (funct3 != 3'b010);
      end
      OPC_OP_IMM: begin
        o_imm      = imm_i;
        o_src2_imm = 1'b1;
        o_gpr_wen  = 1'b1;
        o_alu_op   = alu_sel(funct3, (funct3 == 3'b101) && funct7[5]);
        if (funct3 == 3'b001) begin
          o_invalid = (funct7 != 7'b0000000);
        end else if (funct3 == 3'b101) begin
          o_invalid = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
        end
      end
      OPC_OP: begin
        o_gpr_wen = 1'b1;
        o_alu_op  = alu_sel(funct3, funct7[5]);
        if (funct7 == 7'b0100000) begin
          o_invalid = (funct3 != 3'b000) && (funct3 != 3'b101);
        end else begin
          o_invalid = (funct7 != 7'b0000000);
        end
      end
      default: o_invalid = 1'b1;
    endcase
    // an illegal instruction must not touch state or redirect
    if (o_invalid) begin
      o_gpr_wen   = 1'b0;
      o_mem_ren   = 1'b0;
      o_mem_wen   = 1'b0;
      o_is_branch = 1'b0;
      o_is_jal    = 1'b0;
      o_is_jalr   = 1'b0;
    end
  end

endmodule

// File: logic/id_pipe_latch.sv
// decode stage latch with valid flag, allowin and out-valid logic
`timescale 1ns/1ps
`include "id_settings.svh"

module id_pipe_latch import id_types_pkg::*; (
  input  logic  i_clk,
  input  logic  i_rst_n,
  input  logic  i_fs_valid,
  input  inst_t i_fs_inst,
  input  pc_t   i_fs_pc,
  input  logic  i_es_allowin,
  input  logic  i_load_stall,
  output logic  o_ds_allowin,
  output logic  o_es_valid,
  output logic  o_fire,
  output inst_t o_inst,
  output pc_t   o_pc
);

  logic ds_valid;
  logic ready_go;

  assign ready_go     = ~i_load_stall;
  assign o_ds_allowin = ~ds_valid | (ready_go & i_es_allowin);
  assign o_es_valid   = ds_valid & ready_go;
  assign o_fire       = o_es_valid & i_es_allowin;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_valid;  // empties when fetch has nothing
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_inst <= '0;
      o_pc   <= `RESET_PC;
    end else if (i_fs_valid && o_ds_allowin) begin
      o_inst <= i_fs_inst;
      o_pc   <= i_fs_pc;
    end
  end

endmodule

// File: logic/rv_isa_pkg.sv
// rv32i major opcode, branch function and alu operation enums
package rv_isa_pkg;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_e;

  // funct3 of branch instructions
  typedef enum logic [2:0] {
    BR_BEQ  = 3'b000,
    BR_BNE  = 3'b001,
    BR_BLT  = 3'b100,
    BR_BGE  = 3'b101,
    BR_BLTU = 3'b110,
    BR_BGEU = 3'b111
  } br_func_e;

  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_AND    = 4'd2,
    ALU_OR     = 4'd3,
    ALU_XOR    = 4'd4,
    ALU_SLT    = 4'd5,
    ALU_SLTU   = 4'd6,
    ALU_SLL    = 4'd7,
    ALU_SRL    = 4'd8,
    ALU_SRA    = 4'd9,
    ALU_PASS_B = 4'd10  // lui
  } alu_op_e;

endpackage

// File: logic/id_types_pkg.sv
// data word, register address, pc and instruction typedefs
`include "id_settings.svh"

package id_types_pkg;

  // one register or alu word
  typedef logic [`XLEN-1:0] xlen_t;

  // index into the gpr file
  typedef logic [`GPR_ADDR_WD-1:0] gpr_addr_t;

  // instruction address
  typedef logic [`XLEN-1:0] pc_t;

  // raw instruction as fetched
  typedef logic [`INST_WD-1:0] inst_t;

endpackage

// File: logic/id_settings.svh
// data width, instruction width, register count, register address width, reset pc
`ifndef ID_SETTINGS_SVH
`define ID_SETTINGS_SVH

// rv32i word and instruction
`define XLEN        32
`define INST_WD     32

// general purpose registers
`define GPR_NUM     32
`define GPR_ADDR_WD 5

// pc held by the decode latch out of reset
`define RESET_PC    32'h8000_0000

`endif
